// File: acc_cfg_pkg.sv
package acc_cfg_pkg;

  // Array and datapath dimensions
  localparam int ROWS        = 4;
  localparam int COLS        = 4;
  localparam int LANE_W      = 8;
  localparam int WORD_W      = 32;
  localparam int ADDR_W      = 16;
  localparam int LEN_W       = 16;

  // Buffering and credits
  localparam int FIFO_DEPTH  = 4;
  localparam int NUM_READERS = 3;
  localparam int OUT_CREDITS = 4;
  localparam int REG_ADDR_W  = 3;

  localparam int COL_W         = $clog2(COLS);
  localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
  localparam int CREDIT_W      = $clog2(FIFO_DEPTH + 1);
  localparam int ID_FIFO_DEPTH = NUM_READERS * FIFO_DEPTH;
  localparam int ID_PTR_W      = $clog2(ID_FIFO_DEPTH);
  localparam int OUT_CREDIT_W  = $clog2(OUT_CREDITS + 1);

endpackage

// File: acc_types_pkg.sv
package acc_types_pkg;

  import acc_cfg_pkg::*;

  // One memory word seen as ROWS lanes
  typedef logic [ROWS-1:0][LANE_W-1:0] lanes_t;

  // One channel's job
  typedef struct packed {
    logic [ADDR_W-1:0] base;
    logic [LEN_W-1:0]  len;
  } desc_t;

  typedef logic [1:0] req_id_t;

  // Register map
  localparam logic [REG_ADDR_W-1:0] REG_K_BASE = REG_ADDR_W'(0);
  localparam logic [REG_ADDR_W-1:0] REG_K_LEN  = REG_ADDR_W'(1);
  localparam logic [REG_ADDR_W-1:0] REG_X_BASE = REG_ADDR_W'(2);
  localparam logic [REG_ADDR_W-1:0] REG_X_LEN  = REG_ADDR_W'(3);
  localparam logic [REG_ADDR_W-1:0] REG_A_BASE = REG_ADDR_W'(4);
  localparam logic [REG_ADDR_W-1:0] REG_A_LEN  = REG_ADDR_W'(5);
  localparam logic [REG_ADDR_W-1:0] REG_CTRL   = REG_ADDR_W'(6);

endpackage

// File: mem_req_if.sv
`timescale 1ns/1ns

interface mem_req_if import acc_cfg_pkg::*; ();

  logic              req;
  logic [ADDR_W-1:0] addr;
  logic              gnt;
  // One response per grant, in grant order, never refused
  logic              rvalid;
  logic [WORD_W-1:0] rdata;

  modport reader (output req, output addr, input gnt, input rvalid, input rdata);

  modport arbiter (input req, input addr, output gnt, output rvalid, output rdata);

endinterface

// File: lane_stream_if.sv
`timescale 1ns/1ns

interface lane_stream_if import acc_types_pkg::*; ();

  logic   valid;
  logic   ready;
  lanes_t data;
  logic   last;

  modport source (output valid, output data, output last, input ready);

  modport sink (input valid, input data, input last, output ready);

endinterface

// File: acc_regs.sv
`timescale 1ns/1ns

module acc_regs import acc_cfg_pkg::*, acc_types_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  reg_wr_en,
  input  logic [REG_ADDR_W-1:0] reg_wr_addr,
  input  logic [WORD_W-1:0]     reg_wr_data,
  input  logic [REG_ADDR_W-1:0] reg_rd_addr,
  output logic [WORD_W-1:0]     reg_rd_data,
  output logic                  start,
  output desc_t                 k_desc,
  output desc_t                 x_desc,
  output desc_t                 a_desc,
  input  logic                  job_done
);

  logic       busy;
  logic [7:0] done_cnt;
  logic       ctrl_go;

  // Start request only counts while idle
  assign ctrl_go = reg_wr_en && (reg_wr_addr == REG_CTRL) && reg_wr_data[0] && !busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      k_desc <= '0;
      x_desc <= '0;
      a_desc <= '0;
    end else if (reg_wr_en) begin
      case (reg_wr_addr)
        REG_K_BASE: k_desc.base <= reg_wr_data[ADDR_W-1:0];
        REG_K_LEN:  k_desc.len  <= reg_wr_data[LEN_W-1:0];
        REG_X_BASE: x_desc.base <= reg_wr_data[ADDR_W-1:0];
        REG_X_LEN:  x_desc.len  <= reg_wr_data[LEN_W-1:0];
        REG_A_BASE: a_desc.base <= reg_wr_data[ADDR_W-1:0];
        REG_A_LEN:  a_desc.len  <= reg_wr_data[LEN_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start    <= 1'b0;
      busy     <= 1'b0;
      done_cnt <= '0;
    end else begin
      start <= ctrl_go;
      if (ctrl_go) begin
        busy <= 1'b1;
      end else if (job_done) begin
        busy     <= 1'b0;
        done_cnt <= done_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    reg_rd_data = '0;
    case (reg_rd_addr)
      REG_K_BASE: reg_rd_data[ADDR_W-1:0] = k_desc.base;
      REG_K_LEN:  reg_rd_data[LEN_W-1:0]  = k_desc.len;
      REG_X_BASE: reg_rd_data[ADDR_W-1:0] = x_desc.base;
      REG_X_LEN:  reg_rd_data[LEN_W-1:0]  = x_desc.len;
      REG_A_BASE: reg_rd_data[ADDR_W-1:0] = a_desc.base;
      REG_A_LEN:  reg_rd_data[LEN_W-1:0]  = a_desc.len;
      REG_CTRL: begin
        reg_rd_data[0]    = busy;
        reg_rd_data[15:8] = done_cnt;
      end
      default: ;
    endcase
  end

endmodule

// File: dma_reader.sv
`timescale 1ns/1ns

module dma_reader import acc_cfg_pkg::*, acc_types_pkg::*; (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          start,
  input  desc_t         desc,
  mem_req_if.reader     mem,
  lane_stream_if.source stream
);

  lanes_t                fifo_mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [CREDIT_W-1:0]   fifo_cnt;
  logic [CREDIT_W-1:0]   credits;
  logic [ADDR_W-1:0]     addr_q;
  logic [LEN_W-1:0]      issue_left;
  logic [LEN_W-1:0]      deliver_left;
  logic                  grant;
  logic                  pop;

  // Each credit is one free FIFO slot, so responses always find room
  assign mem.req  = (issue_left != '0) && (credits != '0);
  assign mem.addr = addr_q;
  assign grant    = mem.req && mem.gnt;

  assign stream.valid = (fifo_cnt != '0);
  assign stream.data  = fifo_mem[rd_ptr];
  assign stream.last  = (deliver_left == LEN_W'(1));
  assign pop          = stream.valid && stream.ready;

  always_ff @(posedge clk) begin
    if (mem.rvalid) begin
      fifo_mem[wr_ptr] <= mem.rdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      fifo_cnt     <= '0;
      credits      <= CREDIT_W'(FIFO_DEPTH);
      addr_q       <= '0;
      issue_left   <= '0;
      deliver_left <= '0;
    end else begin
      if (start) begin
        addr_q       <= desc.base;
        issue_left   <= desc.len;
        deliver_left <= desc.len;
      end else begin
        if (grant) begin
          addr_q     <= addr_q + 1'b1;
          issue_left <= issue_left - 1'b1;
        end
        if (pop) begin
          deliver_left <= deliver_left - 1'b1;
        end
      end
      if (mem.rvalid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fifo_cnt <= fifo_cnt + CREDIT_W'(mem.rvalid) - CREDIT_W'(pop);
      credits  <= credits - CREDIT_W'(grant) + CREDIT_W'(pop);
    end
  end

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter import acc_cfg_pkg::*, acc_types_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  mem_req_if.arbiter        rd [NUM_READERS],
  output logic              mem_req,
  output logic [ADDR_W-1:0] mem_addr,
  input  logic              mem_gnt,
  input  logic              mem_rvalid,
  input  logic [WORD_W-1:0] mem_rdata
);

  logic [NUM_READERS-1:0] req_vec;
  logic [ADDR_W-1:0]      addr_arr [NUM_READERS];
  req_id_t                ptr;
  req_id_t                sel;
  logic                   grant;
  req_id_t                id_mem [ID_FIFO_DEPTH];
  logic [ID_PTR_W-1:0]    id_wr_ptr;
  logic [ID_PTR_W-1:0]    id_rd_ptr;
  req_id_t                head_id;

  for (genvar i = 0; i < NUM_READERS; i++) begin : g_port
    assign req_vec[i]   = rd[i].req;
    assign addr_arr[i]  = rd[i].addr;
    assign rd[i].gnt    = grant && (sel == req_id_t'(i));
    assign rd[i].rvalid = mem_rvalid && (head_id == req_id_t'(i));
    assign rd[i].rdata  = mem_rdata;
  end

  // Scan from the far end so the requester nearest ptr wins
  always_comb begin
    int idx;
    sel = ptr;
    for (int k = NUM_READERS - 1; k >= 0; k--) begin
      idx = (int'(ptr) + k) % NUM_READERS;
      if (req_vec[idx]) begin
        sel = req_id_t'(idx);
      end
    end
  end

  assign mem_req  = |req_vec;
  assign mem_addr = addr_arr[sel];
  assign grant    = mem_req && mem_gnt;
  assign head_id  = id_mem[id_rd_ptr];

  always_ff @(posedge clk) begin
    if (grant) begin
      id_mem[id_wr_ptr] <= sel;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr       <= '0;
      id_wr_ptr <= '0;
      id_rd_ptr <= '0;
    end else begin
      if (grant) begin
        ptr <= (sel == req_id_t'(NUM_READERS - 1)) ? '0 : sel + 1'b1;
        id_wr_ptr <= (id_wr_ptr == ID_PTR_W'(ID_FIFO_DEPTH - 1)) ? '0 : id_wr_ptr + 1'b1;
      end
      // Responses come back in grant order
      if (mem_rvalid) begin
        id_rd_ptr <= (id_rd_ptr == ID_PTR_W'(ID_FIFO_DEPTH - 1)) ? '0 : id_rd_ptr + 1'b1;
      end
    end
  end

endmodule

// File: outer_product_array.sv
`timescale 1ns/1ns

module outer_product_array import acc_cfg_pkg::*; (
  input  logic          clk,
  input  logic          arst_n,
  lane_stream_if.sink   k_in,
  lane_stream_if.sink   x_in,
  lane_stream_if.source col_out
);

  logic [LANE_W-1:0] acc [ROWS][COLS];
  logic              draining;
  logic [COL_W-1:0]  col_cnt;
  logic              pair_fire;
  logic              pair_last;
  logic              col_fire;
  logic              col_end;

  // Weight and pixel beats move only as a pair
  assign pair_fire  = k_in.valid && x_in.valid && !draining;
  assign pair_last  = k_in.last && x_in.last;
  assign k_in.ready = pair_fire;
  assign x_in.ready = pair_fire;

  assign col_out.valid = draining;
  assign col_out.last  = (col_cnt == COL_W'(COLS - 1));
  assign col_fire      = col_out.valid && col_out.ready;
  assign col_end       = col_fire && col_out.last;

  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      col_out.data[r] = acc[r][col_cnt];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      draining <= 1'b0;
      col_cnt  <= '0;
      for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
          acc[r][c] <= '0;
        end
      end
    end else begin
      if (pair_fire) begin
        // Low byte of the signed product, wraps mod 256
        for (int r = 0; r < ROWS; r++) begin
          for (int c = 0; c < COLS; c++) begin
            acc[r][c] <= acc[r][c] + x_in.data[r] * k_in.data[c];
          end
        end
        if (pair_last) begin
          draining <= 1'b1;
        end
      end
      if (col_fire) begin
        col_cnt <= col_cnt + 1'b1;
      end
      if (col_end) begin
        draining <= 1'b0;
        col_cnt  <= '0;
        for (int r = 0; r < ROWS; r++) begin
          for (int c = 0; c < COLS; c++) begin
            acc[r][c] <= '0;
          end
        end
      end
    end
  end

endmodule

// File: psum_adder.sv
`timescale 1ns/1ns

module psum_adder import acc_cfg_pkg::*, acc_types_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  lane_stream_if.sink       col_in,
  lane_stream_if.sink       a_in,
  output logic              out_valid,
  output logic [WORD_W-1:0] out_data,
  output logic              out_last,
  input  logic              out_credit,
  output logic              job_done
);

  logic [OUT_CREDIT_W-1:0] credits;
  logic                    has_credit;
  logic                    join_fire;
  lanes_t                  sum;

  // Join of column and partial sum, gated by an output credit
  assign has_credit   = (credits != '0);
  assign col_in.ready = has_credit && a_in.valid;
  assign a_in.ready   = has_credit && col_in.valid;
  assign join_fire    = has_credit && col_in.valid && a_in.valid;

  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      sum[r] = col_in.data[r] + a_in.data[r];
    end
  end

  always_ff @(posedge clk) begin
    if (join_fire) begin
      out_data <= sum;
      out_last <= col_in.last && a_in.last;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      credits   <= OUT_CREDIT_W'(OUT_CREDITS);
    end else begin
      out_valid <= join_fire;
      credits   <= credits - OUT_CREDIT_W'(join_fire) + OUT_CREDIT_W'(out_credit);
    end
  end

  assign job_done = out_valid && out_last;

endmodule

// File: acc_top.sv
`timescale 1ns/1ns

module acc_top import acc_cfg_pkg::*, acc_types_pkg::*; (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  reg_wr_en,
  input  logic [REG_ADDR_W-1:0] reg_wr_addr,
  input  logic [WORD_W-1:0]     reg_wr_data,
  input  logic [REG_ADDR_W-1:0] reg_rd_addr,
  output logic [WORD_W-1:0]     reg_rd_data,
  output logic                  mem_req,
  output logic [ADDR_W-1:0]     mem_addr,
  input  logic                  mem_gnt,
  input  logic                  mem_rvalid,
  input  logic [WORD_W-1:0]     mem_rdata,
  output logic                  out_valid,
  output logic [WORD_W-1:0]     out_data,
  output logic                  out_last,
  input  logic                  out_credit
);

  logic  start;
  logic  job_done;
  desc_t k_desc;
  desc_t x_desc;
  desc_t a_desc;

  // Index 0 weights, 1 pixels, 2 partial sums
  mem_req_if     rd_if [NUM_READERS] ();
  lane_stream_if k_s ();
  lane_stream_if x_s ();
  lane_stream_if a_s ();
  lane_stream_if col_s ();

  acc_regs u_regs (
    .clk(clk), .arst_n(arst_n),
    .reg_wr_en(reg_wr_en), .reg_wr_addr(reg_wr_addr), .reg_wr_data(reg_wr_data),
    .reg_rd_addr(reg_rd_addr), .reg_rd_data(reg_rd_data),
    .start(start), .k_desc(k_desc), .x_desc(x_desc), .a_desc(a_desc),
    .job_done(job_done)
  );

  dma_reader u_rd_k (
    .clk(clk), .arst_n(arst_n), .start(start), .desc(k_desc), .mem(rd_if[0]), .stream(k_s)
  );

  dma_reader u_rd_x (
    .clk(clk), .arst_n(arst_n), .start(start), .desc(x_desc), .mem(rd_if[1]), .stream(x_s)
  );

  dma_reader u_rd_a (
    .clk(clk), .arst_n(arst_n), .start(start), .desc(a_desc), .mem(rd_if[2]), .stream(a_s)
  );

  mem_arbiter u_arb (
    .clk(clk), .arst_n(arst_n), .rd(rd_if),
    .mem_req(mem_req), .mem_addr(mem_addr), .mem_gnt(mem_gnt),
    .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
  );

  outer_product_array u_array (
    .clk(clk), .arst_n(arst_n), .k_in(k_s), .x_in(x_s), .col_out(col_s)
  );

  psum_adder u_adder (
    .clk(clk), .arst_n(arst_n), .col_in(col_s), .a_in(a_s),
    .out_valid(out_valid), .out_data(out_data), .out_last(out_last),
    .out_credit(out_credit), .job_done(job_done)
  );

endmodule

// File: tb_acc_top.sv
`timescale 1ns/1ns

module tb_acc_top import acc_cfg_pkg::*, acc_types_pkg::*; ();

  logic                  clk = 1'b0;
  logic                  arst_n = 1'b0;
  logic                  reg_wr_en = 1'b0;
  logic [REG_ADDR_W-1:0] reg_wr_addr = '0;
  logic [WORD_W-1:0]     reg_wr_data = '0;
  logic [REG_ADDR_W-1:0] reg_rd_addr = '0;
  logic [WORD_W-1:0]     reg_rd_data;
  logic                  mem_req;
  logic [ADDR_W-1:0]     mem_addr;
  logic                  mem_gnt = 1'b0;
  logic                  mem_rvalid = 1'b0;
  logic [WORD_W-1:0]     mem_rdata = '0;
  logic                  out_valid;
  logic [WORD_W-1:0]     out_data;
  logic                  out_last;
  logic                  out_credit = 1'b0;

  logic [WORD_W-1:0] mem_model [2**ADDR_W];
  logic [31:0]       lcg_state = 32'h4fd1;
  logic              stall_grants = 1'b0;
  logic              hold_credits = 1'b0;
  int                owed = 0;
  int                cycle = 0;
  int                last_due = 0;
  int                rsp_due_q [$];
  logic [WORD_W-1:0] rsp_data_q [$];
  logic [WORD_W-1:0] rx_data_q [$];
  logic              rx_last_q [$];
  logic [WORD_W-1:0] exp_q [$];

  acc_top u_acc_top (
    .clk(clk), .arst_n(arst_n),
    .reg_wr_en(reg_wr_en), .reg_wr_addr(reg_wr_addr), .reg_wr_data(reg_wr_data),
    .reg_rd_addr(reg_rd_addr), .reg_rd_data(reg_rd_data),
    .mem_req(mem_req), .mem_addr(mem_addr), .mem_gnt(mem_gnt),
    .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
    .out_valid(out_valid), .out_data(out_data), .out_last(out_last),
    .out_credit(out_credit)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s got=%08h exp=%08h", $time, name, got, exp));
    end
  endtask

  // Memory model with random grants and in-order responses 2 to 4 cycles later
  always @(negedge clk) begin
    logic [31:0] r;
    int          due;
    cycle++;
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
      mem_rvalid = 1'b1;
      mem_rdata  = rsp_data_q.pop_front();
      due        = rsp_due_q.pop_front();
    end else begin
      mem_rvalid = 1'b0;
    end
    r = rand_next();
    mem_gnt = stall_grants ? (r[17:16] != 2'b00) : 1'b1;
    #1;
    if (mem_req && mem_gnt) begin
      due = cycle + 2 + int'(r[15:8]) % 3;
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      rsp_due_q.push_back(due);
      rsp_data_q.push_back(mem_model[mem_addr]);
    end
  end

  // Result receiver and credit return
  always @(negedge clk) begin
    if (out_valid) begin
      rx_data_q.push_back(out_data);
      rx_last_q.push_back(out_last);
      owed++;
      check_value("credit_overrun", 32'(owed > OUT_CREDITS), 32'd0);
    end
    if (!hold_credits && owed > 0) begin
      out_credit = 1'b1;
      owed--;
    end else begin
      out_credit = 1'b0;
    end
  end

  task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
    @(negedge clk);
    reg_wr_en   = 1'b1;
    reg_wr_addr = addr;
    reg_wr_data = data;
    @(negedge clk);
    reg_wr_en = 1'b0;
  endtask

  task automatic reg_read(input logic [REG_ADDR_W-1:0] addr, output logic [WORD_W-1:0] data);
    @(negedge clk);
    reg_rd_addr = addr;
    #1;
    data = reg_rd_data;
  endtask

  task automatic apply_reset();
    int cycles;
    cycles = 0;
    while (owed != 0 || rsp_due_q.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > 500) begin
        abort_run("timeout: credits or memory responses still pending before reset");
      end
    end
    rx_data_q.delete();
    rx_last_q.delete();
    exp_q.delete();
    hold_credits = 1'b0;
    stall_grants = 1'b0;
    @(negedge clk);
    arst_n = 1'b0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
  endtask

  task automatic load_job_data(input logic [ADDR_W-1:0] kb, input logic [ADDR_W-1:0] xb,
                               input logic [ADDR_W-1:0] ab, input int len);
    // Stay clear of the grant draws made on the falling edge
    @(posedge clk);
    for (int i = 0; i < len; i++) begin
      mem_model[kb + ADDR_W'(i)] = rand_next();
      mem_model[xb + ADDR_W'(i)] = rand_next();
    end
    for (int c = 0; c < COLS; c++) begin
      mem_model[ab + ADDR_W'(c)] = rand_next();
    end
  endtask

  // Lane r of column c is the sum of x[r]*k[c] over beats plus a_c[r] mod 256
  task automatic add_expected(input logic [ADDR_W-1:0] kb, input logic [ADDR_W-1:0] xb,
                              input logic [ADDR_W-1:0] ab, input int len);
    logic [WORD_W-1:0] kw;
    logic [WORD_W-1:0] xw;
    logic [WORD_W-1:0] aw;
    logic [WORD_W-1:0] word;
    logic [7:0]        lane;
    for (int c = 0; c < COLS; c++) begin
      aw = mem_model[ab + ADDR_W'(c)];
      for (int r = 0; r < ROWS; r++) begin
        lane = aw[r*8 +: 8];
        for (int b = 0; b < len; b++) begin
          kw   = mem_model[kb + ADDR_W'(b)];
          xw   = mem_model[xb + ADDR_W'(b)];
          lane = lane + xw[r*8 +: 8] * kw[c*8 +: 8];
        end
        word[r*8 +: 8] = lane;
      end
      exp_q.push_back(word);
    end
  endtask

  task automatic start_job(input logic [ADDR_W-1:0] kb, input logic [ADDR_W-1:0] xb,
                           input logic [ADDR_W-1:0] ab, input int len);
    reg_write(REG_K_BASE, 32'(kb));
    reg_write(REG_K_LEN, 32'(len));
    reg_write(REG_X_BASE, 32'(xb));
    reg_write(REG_X_LEN, 32'(len));
    reg_write(REG_A_BASE, 32'(ab));
    reg_write(REG_A_LEN, 32'(COLS));
    reg_write(REG_CTRL, 32'd1);
  endtask

  task automatic wait_beats(input int n);
    int cycles;
    cycles = 0;
    while (rx_data_q.size() < n) begin
      @(negedge clk);
      cycles++;
      if (cycles > 2000) begin
        abort_run($sformatf("timeout: only %0d of %0d output beats arrived",
                            rx_data_q.size(), n));
      end
    end
  endtask

  task automatic wait_idle();
    logic [WORD_W-1:0] ctrl;
    int                tries;
    tries = 0;
    reg_read(REG_CTRL, ctrl);
    while (ctrl[0]) begin
      tries++;
      if (tries > 200) begin
        abort_run("timeout: busy never dropped after the job");
      end
      reg_read(REG_CTRL, ctrl);
    end
  endtask

  task automatic compare_results();
    check_value("beat_count", rx_data_q.size(), exp_q.size());
    for (int i = 0; i < exp_q.size(); i++) begin
      check_value($sformatf("out_data[%0d]", i), rx_data_q[i], exp_q[i]);
      check_value($sformatf("out_last[%0d]", i), 32'(rx_last_q[i]),
                  32'((i % COLS) == COLS - 1));
    end
    rx_data_q.delete();
    rx_last_q.delete();
    exp_q.delete();
  endtask

  task automatic readback_regs();
    logic [WORD_W-1:0] val;
    logic [WORD_W-1:0] got;
    apply_reset();
    reg_read(REG_CTRL, got);
    check_value("ctrl_after_reset", got, 32'd0);
    for (int i = 0; i < 6; i++) begin
      val = 32'h0000_a000 + 32'(i) * 32'h0000_0123;
      reg_write(REG_ADDR_W'(i), val);
    end
    for (int i = 0; i < 6; i++) begin
      val = 32'h0000_a000 + 32'(i) * 32'h0000_0123;
      reg_read(REG_ADDR_W'(i), got);
      check_value($sformatf("reg[%0d]", i), got, val);
    end
  endtask

  task automatic single_beat_job();
    apply_reset();
    load_job_data(16'h0010, 16'h0020, 16'h0030, 1);
    add_expected(16'h0010, 16'h0020, 16'h0030, 1);
    start_job(16'h0010, 16'h0020, 16'h0030, 1);
    wait_beats(COLS);
    wait_idle();
    compare_results();
  endtask

  task automatic multi_beat_job();
    logic [WORD_W-1:0] ctrl;
    apply_reset();
    stall_grants = 1'b1;
    load_job_data(16'h0100, 16'h0140, 16'h0180, 6);
    add_expected(16'h0100, 16'h0140, 16'h0180, 6);
    start_job(16'h0100, 16'h0140, 16'h0180, 6);
    wait_beats(COLS);
    wait_idle();
    compare_results();
    reg_read(REG_CTRL, ctrl);
    check_value("ctrl_after_job", ctrl, 32'h0000_0100);
  endtask

  // Credits stay withheld through one job so the second job must stall
  task automatic output_backpressure();
    apply_reset();
    hold_credits = 1'b1;
    load_job_data(16'h0800, 16'h0840, 16'h0880, 2);
    add_expected(16'h0800, 16'h0840, 16'h0880, 2);
    start_job(16'h0800, 16'h0840, 16'h0880, 2);
    wait_beats(COLS);
    wait_idle();
    load_job_data(16'h0900, 16'h0940, 16'h0980, 4);
    add_expected(16'h0900, 16'h0940, 16'h0980, 4);
    start_job(16'h0900, 16'h0940, 16'h0980, 4);
    repeat (40) @(negedge clk);
    check_value("beats_while_held", rx_data_q.size(), COLS);
    hold_credits = 1'b0;
    wait_beats(2 * COLS);
    wait_idle();
    compare_results();
  endtask

  task automatic back_to_back_jobs();
    logic [WORD_W-1:0] ctrl;
    apply_reset();
    load_job_data(16'h0200, 16'h0300, 16'h0400, 3);
    add_expected(16'h0200, 16'h0300, 16'h0400, 3);
    start_job(16'h0200, 16'h0300, 16'h0400, 3);
    reg_write(REG_CTRL, 32'd1);
    wait_beats(COLS);
    wait_idle();
    compare_results();
    reg_read(REG_CTRL, ctrl);
    check_value("ctrl_first_job", ctrl, 32'h0000_0100);
    load_job_data(16'h0500, 16'h0600, 16'h0700, 5);
    add_expected(16'h0500, 16'h0600, 16'h0700, 5);
    start_job(16'h0500, 16'h0600, 16'h0700, 5);
    wait_beats(COLS);
    wait_idle();
    compare_results();
    reg_read(REG_CTRL, ctrl);
    check_value("ctrl_second_job", ctrl, 32'h0000_0200);
  endtask

  initial begin
    for (int i = 0; i < 2**ADDR_W; i++) begin
      mem_model[ADDR_W'(i)] = {~16'(i), 16'(i)};
    end
    readback_regs();
    single_beat_job();
    multi_beat_job();
    output_backpressure();
    back_to_back_jobs();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: tb.f
acc_cfg_pkg.sv
acc_types_pkg.sv
mem_req_if.sv
lane_stream_if.sv
acc_regs.sv
dma_reader.sv
mem_arbiter.sv
outer_product_array.sv
psum_adder.sv
acc_top.sv
tb_acc_top.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module tb_acc_top -f tb.f -o tb_sim > build.log 2>&1 \
  || { cat build.log; exit 1; }
./obj_dir/tb_sim 2>&1 | tee sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || grep -q "STATUS: PASS" sim.log
